// ==== Bender.yml ====
package:
  name: det_accel

sources:
  - hdl/det_pkg.sv
  - hdl/det_regs.sv
  - hdl/det_dma.sv
  - hdl/det_matrix_ram.sv
  - hdl/det_row_map.sv
  - hdl/det_divider.sv
  - hdl/det_engine.sv
  - hdl/det_top.sv
  - target: simulation
    files:
      - verification/det_asserts.sv
      - verification/det_tb.sv

// ==== hdl/det_divider.sv ====
// sequential signed 64 by 32 restoring divider for the exact elimination divides; done 65 cycles after start
`timescale 1ns/1ns

module det_divider (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_start,
	input  logic signed [63:0] i_dividend,
	input  det_pkg::det_word_t i_divisor,
	output logic               o_done,
	output det_pkg::det_word_t o_quotient
);
	import det_pkg::*;

	logic [WORD_W:0]     rem;      // partial remainder plus carry bit
	logic [2*WORD_W-1:0] quo;      // dividend bits out, quotient bits in
	logic [WORD_W-1:0]   dvs;      // divisor magnitude
	logic                neg;
	logic [5:0]          count;
	logic                busy;
	logic [WORD_W:0]     trial;
	logic                fits;
	logic [WORD_W:0]     rem_next;
	logic [2*WORD_W-1:0] quo_next;

	// one restoring step
	always_comb begin
		trial    = {rem[WORD_W-1:0], quo[2*WORD_W-1]};
		fits     = trial >= {1'b0, dvs};
		rem_next = fits ? trial - {1'b0, dvs} : trial;
		quo_next = {quo[2*WORD_W-2:0], fits};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy   <= 1'b0;
			o_done <= 1'b0;
			count  <= '0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy  <= 1'b1;
				count <= '0;
				rem   <= '0;
				quo   <= i_dividend[63] ? -i_dividend : i_dividend; // magnitudes only
				dvs   <= i_divisor[WORD_W-1] ? -i_divisor : i_divisor;
				neg   <= i_dividend[63] ^ i_divisor[WORD_W-1];
			end else if (busy) begin
				rem   <= rem_next;
				quo   <= quo_next;
				count <= count + 1'b1;
				if (count == 6'd63) begin // 64th step
					busy       <= 1'b0;
					o_done     <= 1'b1;
					o_quotient <= neg ? -quo_next[WORD_W-1:0] : quo_next[WORD_W-1:0];
				end
			end
		end
	end

endmodule

// ==== hdl/det_dma.sv ====
// bus-master reader; fetches N*N words from the pointer and lays them row-major into the matrix RAM
`timescale 1ns/1ns

module det_dma (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_start,
	input  det_pkg::bus_addr_t i_ptr,
	input  det_pkg::mx_size_t  i_size,
	input  logic               i_waitrequest,
	input  det_pkg::det_word_t i_readdata,
	input  logic               i_readdatavalid,
	output det_pkg::bus_addr_t o_address,
	output logic               o_read,
	output det_pkg::mx_addr_t  o_load_addr,
	output det_pkg::det_word_t o_load_data,
	output logic               o_load_we,
	output logic               o_load_done
);
	import det_pkg::*;

	logic [6:0] total;    // N*N, up to 64
	logic [6:0] req_cnt;  // accepted requests so far
	mx_idx_t    last_idx;
	mx_idx_t    rx_row;
	mx_idx_t    rx_col;
	logic       rx_active;
	logic       rx_last;  // final word in the write stage

	assign total    = i_size * i_size;
	assign last_idx = mx_idx_t'(i_size - 1'b1);

	////////////////////////////////////////////////////////////////////////////
	// request side, held while waitrequest is up
	always_ff @(posedge clk) begin
		if (reset) begin
			o_read    <= 1'b0;
			o_address <= '0;
			req_cnt   <= '0;
		end else if (i_start) begin
			o_read    <= 1'b1;
			o_address <= i_ptr;
			req_cnt   <= '0;
		end else if (o_read && !i_waitrequest) begin
			req_cnt <= req_cnt + 1'b1;
			if (req_cnt == total - 1'b1)
				o_read <= 1'b0; // last one accepted
			else
				o_address <= o_address + 32'd4;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// receive side, in order
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_active   <= 1'b0;
			rx_last     <= 1'b0;
			o_load_we   <= 1'b0;
			o_load_done <= 1'b0;
		end else begin
			o_load_we   <= 1'b0;
			o_load_done <= rx_last; // last word lands in ram at this edge
			rx_last     <= 1'b0;
			if (i_start) begin
				rx_active <= 1'b1;
				rx_row    <= '0;
				rx_col    <= '0;
			end else if (rx_active && i_readdatavalid) begin
				o_load_we   <= 1'b1;
				o_load_addr <= rx_row * MAX_N + rx_col;
				o_load_data <= i_readdata;
				if (rx_col == last_idx) begin
					rx_col <= '0;
					rx_row <= rx_row + 1'b1;
					if (rx_row == last_idx) begin
						rx_active <= 1'b0;
						rx_last   <= 1'b1;
					end
				end else begin
					rx_col <= rx_col + 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/det_engine.sv ====
// fraction-free elimination FSM; finds pivots, rotates rows on zero pivots and reports the signed determinant
`timescale 1ns/1ns

module det_engine (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_start,
	input  det_pkg::mx_size_t  i_size,
	input  det_pkg::det_word_t i_rd_data,
	input  det_pkg::mx_idx_t   i_phys_a,
	input  det_pkg::mx_idx_t   i_phys_b,
	input  logic               i_div_done,
	input  det_pkg::det_word_t i_quotient,
	output det_pkg::mx_addr_t  o_rd_addr,
	output det_pkg::mx_addr_t  o_wr_addr,
	output det_pkg::det_word_t o_wr_data,
	output logic               o_wr_we,
	output logic               o_map_init,
	output logic               o_map_rotate,
	output det_pkg::mx_idx_t   o_pivot,
	output det_pkg::mx_idx_t   o_lookup_a,
	output det_pkg::mx_idx_t   o_lookup_b,
	output logic               o_div_start,
	output logic signed [63:0] o_dividend,
	output det_pkg::det_word_t o_divisor,
	output logic               o_done,
	output det_pkg::det_word_t o_result,
	output logic               o_singular
);
	import det_pkg::*;

	det_state_e state;
	mx_idx_t    k;           // current column
	mx_idx_t    last_idx;
	mx_size_t   remaining;   // rows still in play
	mx_size_t   rot_cnt;     // zero pivots seen in this column
	det_word_t  piv;
	det_word_t  prev;        // previous pivot starting at 1
	logic       sign;
	mx_idx_t    pl_j;
	logic       pl_col;      // high while reading the left column
	logic       pl_v;
	logic       pl_wcol;
	mx_idx_t    pl_wj;
	mx_idx_t    si;
	mx_idx_t    sj;
	logic       div_issued;
	logic       in_sweep;
	mx_idx_t    rd_row;
	mx_idx_t    rd_col;
	det_word_t  top_row  [MAX_N];
	det_word_t  left_col [MAX_N];

	assign last_idx     = mx_idx_t'(i_size - 1'b1);
	assign remaining    = i_size - k;
	assign in_sweep     = (state == SWEEP_READ) || (state == SWEEP_DIV) || (state == SWEEP_WRITE);
	assign o_map_init   = (state == INIT);
	assign o_map_rotate = (state == PIVOT_CHECK) && (i_rd_data == '0);
	assign o_pivot      = k;
	assign o_lookup_a   = in_sweep ? si : k;
	assign o_lookup_b   = pl_j; // column rows during preload

	// read address by phase
	always_comb begin
		rd_row = (state == PRELOAD && pl_col) ? i_phys_b : i_phys_a;
		case (state)
			PIVOT_READ: rd_col = k;
			PRELOAD:    rd_col = pl_col ? k : pl_j;
			default:    rd_col = sj;
		endcase
	end

	assign o_rd_addr   = rd_row * MAX_N + rd_col;
	assign o_wr_addr   = i_phys_a * MAX_N + sj;
	assign o_wr_data   = i_quotient;
	assign o_wr_we     = (state == SWEEP_WRITE);
	assign o_div_start = (state == SWEEP_DIV) && !div_issued; // first cycle, ram data valid
	assign o_dividend  = piv * i_rd_data - left_col[si] * top_row[sj];
	assign o_divisor   = prev;
	assign o_done      = (state == FINISH) || (state == SINGULAR);

	////////////////////////////////////////////////////////////////////////////
	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= IDLE;
			pl_v       <= 1'b0;
			div_issued <= 1'b0;
			o_result   <= '0;
			o_singular <= 1'b0;
		end else begin
			pl_v <= (state == PRELOAD);
			case (state)
				IDLE: begin
					if (i_start)
						state <= INIT; // matrix is loaded
				end
				INIT: begin
					k       <= '0;
					prev    <= 32'sd1;
					sign    <= 1'b0;
					rot_cnt <= '0;
					state   <= PIVOT_READ;
				end
				PIVOT_READ: state <= PIVOT_CHECK;
				PIVOT_CHECK: begin
					if (i_rd_data != '0) begin
						piv     <= i_rd_data;
						rot_cnt <= '0;
						pl_j    <= k + 1'b1;
						pl_col  <= 1'b0;
						state   <= (k == last_idx) ? FINISH : PRELOAD;
					end else begin
						rot_cnt <= rot_cnt + 1'b1;
						if (!remaining[0])
							sign <= ~sign; // even length cycle is an odd permutation
						state <= (rot_cnt == remaining - 1'b1) ? SINGULAR : PIVOT_READ;
					end
				end
				PRELOAD: begin
					if (pl_j == last_idx) begin
						pl_j   <= k + 1'b1;
						pl_col <= 1'b1;
						if (pl_col) begin // last column read issued
							si    <= k + 1'b1;
							sj    <= k + 1'b1;
							state <= SWEEP_READ;
						end
					end else begin
						pl_j <= pl_j + 1'b1;
					end
				end
				SWEEP_READ: begin
					div_issued <= 1'b0;
					state      <= SWEEP_DIV;
				end
				SWEEP_DIV: begin
					div_issued <= 1'b1;
					if (i_div_done)
						state <= SWEEP_WRITE;
				end
				SWEEP_WRITE: begin
					if (sj == last_idx) begin
						sj    <= k + 1'b1;
						si    <= si + 1'b1;
						state <= (si == last_idx) ? NEXT_COL : SWEEP_READ;
					end else begin
						sj    <= sj + 1'b1;
						state <= SWEEP_READ;
					end
				end
				NEXT_COL: begin
					prev  <= piv; // exact divisor for the next column
					k     <= k + 1'b1;
					state <= PIVOT_READ;
				end
				FINISH: begin
					o_result   <= sign ? -piv : piv;
					o_singular <= 1'b0;
					state      <= IDLE;
				end
				SINGULAR: begin
					o_result   <= SINGULAR_RESULT;
					o_singular <= 1'b1;
					state      <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// preload capture one cycle behind the read
	always_ff @(posedge clk) begin
		pl_wcol <= pl_col;
		pl_wj   <= pl_j;
		if (pl_v) begin
			if (pl_wcol)
				left_col[pl_wj] <= i_rd_data;
			else
				top_row[pl_wj] <= i_rd_data;
		end
	end

endmodule

// ==== hdl/det_matrix_ram.sv ====
// matrix word store; load port for the dma, registered read and plain write for the engine
`timescale 1ns/1ns

module det_matrix_ram (
	input  logic               clk,
	input  det_pkg::mx_addr_t  i_load_addr,
	input  det_pkg::det_word_t i_load_data,
	input  logic               i_load_we,
	input  det_pkg::mx_addr_t  i_rd_addr,
	input  det_pkg::mx_addr_t  i_wr_addr,
	input  det_pkg::det_word_t i_wr_data,
	input  logic               i_wr_we,
	output det_pkg::det_word_t o_rd_data
);
	import det_pkg::*;

	localparam int DEPTH = int'(MAX_N) * int'(MAX_N);

	det_word_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (i_load_we)
			mem[i_load_addr] <= i_load_data; // load owns the port
		else if (i_wr_we)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr]; // one cycle read
	end

endmodule

// ==== hdl/det_pkg.sv ====
// shared widths, register map, status bits and engine states; imported by every determinant block
package det_pkg;

	////////////////////////////////////////////////////////////////////////////
	// matrix geometry
	localparam logic [3:0] MAX_N  = 4'd8; // largest matrix side
	localparam int         IDX_W  = 3;    // row or column index
	localparam int         SIZE_W = 4;    // holds 1..MAX_N
	localparam int         WORD_W = 32;

	typedef logic signed [WORD_W-1:0] det_word_t; // signed integer entry
	typedef logic [IDX_W-1:0]         mx_idx_t;
	typedef logic [SIZE_W-1:0]        mx_size_t;
	typedef logic [5:0]               mx_addr_t;  // phys row * MAX_N + col
	typedef logic [31:0]              bus_addr_t; // byte address on the master bus

	////////////////////////////////////////////////////////////////////////////
	// slave register map
	localparam logic REG_PTR    = 1'b0; // write side
	localparam logic REG_RESULT = 1'b0; // read side
	localparam logic REG_LEN    = 1'b1; // write starts a run
	localparam logic REG_STATUS = 1'b1; // read side

	localparam int STAT_BUSY_BIT     = 0;
	localparam int STAT_SINGULAR_BIT = 1; // needed since all ones is also det -1

	localparam det_word_t SINGULAR_RESULT = 32'hffff_ffff;

	// elimination FSM
	typedef enum logic [3:0] {
		IDLE,
		INIT,        // reset row map and sign
		PIVOT_READ,
		PIVOT_CHECK, // zero pivot rotates
		PRELOAD,     // pivot row and column into local arrays
		SWEEP_READ,
		SWEEP_DIV,
		SWEEP_WRITE,
		NEXT_COL,
		FINISH,
		SINGULAR
	} det_state_e;

endpackage

// ==== hdl/det_regs.sv ====
// processor register block; holds pointer and size, starts a run on a size write, reads back result and status
`timescale 1ns/1ns

module det_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_slave_address,
	input  logic               i_slave_write,
	input  logic               i_slave_read,
	input  det_pkg::det_word_t i_slave_writedata,
	input  logic               i_done,
	input  det_pkg::det_word_t i_result,
	input  logic               i_singular,
	output det_pkg::det_word_t o_slave_readdata,
	output logic               o_irq,
	output logic               o_start,
	output det_pkg::bus_addr_t o_ptr,
	output det_pkg::mx_size_t  o_size
);
	import det_pkg::*;

	logic      busy;
	logic      len_write;
	det_word_t status;

	assign len_write = i_slave_write && (i_slave_address == REG_LEN) && !busy; // dropped while busy

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			o_start <= 1'b0;
			o_irq   <= 1'b0;
			o_size  <= '0;
		end else begin
			o_start <= len_write; // kicks the dma
			if (len_write) begin
				busy   <= 1'b1;
				o_size <= i_slave_writedata[SIZE_W-1:0];
			end else if (i_done) begin
				busy <= 1'b0; // clears together with irq rising
			end
			if (i_done)
				o_irq <= 1'b1;
			else if (i_slave_read)
				o_irq <= 1'b0; // any read acks
		end
	end

	always_ff @(posedge clk) begin
		if (i_slave_write && i_slave_address == REG_PTR)
			o_ptr <= i_slave_writedata;
	end

	always_comb begin
		status                    = '0;
		status[STAT_BUSY_BIT]     = busy;
		status[STAT_SINGULAR_BIT] = i_singular; // held from the last run
	end

	// zero wait readback
	always_comb begin
		case (i_slave_address)
			REG_RESULT: o_slave_readdata = i_result;
			REG_STATUS: o_slave_readdata = status;
			default:    o_slave_readdata = '0;
		endcase
	end

endmodule

// ==== hdl/det_row_map.sv ====
// logical to physical row table for the engine; identity on init, cyclic shift of rows on rotate
`timescale 1ns/1ns

module det_row_map (
	input  logic              clk,
	input  logic              reset,
	input  logic              i_init,
	input  logic              i_rotate,
	input  det_pkg::mx_idx_t  i_pivot,
	input  det_pkg::mx_size_t i_size,
	input  det_pkg::mx_idx_t  i_lookup_a,
	input  det_pkg::mx_idx_t  i_lookup_b,
	output det_pkg::mx_idx_t  o_phys_a,
	output det_pkg::mx_idx_t  o_phys_b
);
	import det_pkg::*;

	mx_idx_t row_tbl [MAX_N];
	mx_idx_t last_idx;

	assign last_idx = mx_idx_t'(i_size - 1'b1);

	always_ff @(posedge clk) begin
		if (reset || i_init) begin
			for (int v = 0; v < MAX_N; v++)
				row_tbl[v] <= mx_idx_t'(v);
		end else if (i_rotate) begin
			row_tbl[i_pivot] <= row_tbl[last_idx]; // bottom row up to pivot
			for (int v = 1; v < MAX_N; v++) begin
				if (v > i_pivot && v <= last_idx)
					row_tbl[v] <= row_tbl[v-1]; // rest slide down one
			end
		end
	end

	// combinational lookups
	assign o_phys_a = row_tbl[i_lookup_a];
	assign o_phys_b = row_tbl[i_lookup_b];

endmodule

// ==== hdl/det_top.sv ====
// determinant accelerator top; slave registers in front, bus-master fetch behind, engine in between
`timescale 1ns/1ns

module det_top (
	input  logic               clk,
	input  logic               reset,
	input  logic               i_slave_address,
	input  logic               i_slave_write,
	input  det_pkg::det_word_t i_slave_writedata,
	input  logic               i_slave_read,
	output det_pkg::det_word_t o_slave_readdata,
	output logic               o_irq,
	output det_pkg::bus_addr_t o_address,
	output logic               o_read,
	input  logic               i_waitrequest,
	input  det_pkg::det_word_t i_readdata,
	input  logic               i_readdatavalid
);
	import det_pkg::*;

	logic               start, done, singular;
	bus_addr_t          ptr;
	mx_size_t           size;
	det_word_t          result;
	mx_addr_t           load_addr, rd_addr, wr_addr;
	det_word_t          load_data, rd_data, wr_data;
	logic               load_we, load_done, wr_we;
	logic               map_init, map_rotate;
	mx_idx_t            pivot, lookup_a, lookup_b, phys_a, phys_b;
	logic               div_start, div_done;
	logic signed [63:0] dividend;
	det_word_t          divisor, quotient;

	det_regs u_regs (
		.clk, .reset,
		.i_slave_address, .i_slave_write, .i_slave_read, .i_slave_writedata,
		.i_done(done), .i_result(result), .i_singular(singular),
		.o_slave_readdata, .o_irq, .o_start(start), .o_ptr(ptr), .o_size(size)
	);

	// fetch N*N words
	det_dma u_dma (
		.clk, .reset, .i_start(start), .i_ptr(ptr), .i_size(size),
		.i_waitrequest, .i_readdata, .i_readdatavalid, .o_address, .o_read,
		.o_load_addr(load_addr), .o_load_data(load_data), .o_load_we(load_we),
		.o_load_done(load_done)
	);

	det_matrix_ram u_ram (
		.clk, .i_load_addr(load_addr), .i_load_data(load_data), .i_load_we(load_we),
		.i_rd_addr(rd_addr), .i_wr_addr(wr_addr), .i_wr_data(wr_data), .i_wr_we(wr_we),
		.o_rd_data(rd_data)
	);

	det_row_map u_row_map (
		.clk, .reset, .i_init(map_init), .i_rotate(map_rotate), .i_pivot(pivot),
		.i_size(size), .i_lookup_a(lookup_a), .i_lookup_b(lookup_b),
		.o_phys_a(phys_a), .o_phys_b(phys_b)
	);

	det_divider u_divider (
		.clk, .reset, .i_start(div_start), .i_dividend(dividend), .i_divisor(divisor),
		.o_done(div_done), .o_quotient(quotient)
	);

	// starts once the load is complete
	det_engine u_engine (
		.clk, .reset, .i_start(load_done), .i_size(size), .i_rd_data(rd_data),
		.i_phys_a(phys_a), .i_phys_b(phys_b), .i_div_done(div_done), .i_quotient(quotient),
		.o_rd_addr(rd_addr), .o_wr_addr(wr_addr), .o_wr_data(wr_data), .o_wr_we(wr_we),
		.o_map_init(map_init), .o_map_rotate(map_rotate), .o_pivot(pivot),
		.o_lookup_a(lookup_a), .o_lookup_b(lookup_b), .o_div_start(div_start),
		.o_dividend(dividend), .o_divisor(divisor), .o_done(done), .o_result(result),
		.o_singular(singular)
	);

endmodule

// ==== sim.f ====
hdl/det_pkg.sv
hdl/det_regs.sv
hdl/det_dma.sv
hdl/det_matrix_ram.sv
hdl/det_row_map.sv
hdl/det_divider.sv
hdl/det_engine.sv
hdl/det_top.sv
verification/det_asserts.sv
verification/det_tb.sv

// ==== verification/det_asserts.sv ====
// concurrent checks on the elimination FSM and the bus-master port; attached to the RTL by bind
`timescale 1ns/1ns

module det_asserts (
	input logic        clk,
	input logic        reset,
	input logic        i_idle,   // engine parked
	input logic        i_wr_we,
	input logic        i_done,
	input logic        i_hold,   // waitrequest
	input logic        i_read,
	input logic [31:0] i_address
);

	int fail_cnt;

	// no matrix writes from a parked engine
	write_in_idle: assert property (@(posedge clk) disable iff (reset) i_idle |-> !i_wr_we)
		else begin
			fail_cnt++;
			$error("ram write strobe high while the engine is idle");
		end

	done_pulse: assert property (@(posedge clk) disable iff (reset) i_done |=> !i_done)
		else begin
			fail_cnt++;
			$error("engine done held longer than one cycle");
		end

	// request frozen under back-pressure
	hold_request: assert property (@(posedge clk) disable iff (reset)
			i_read && i_hold |=> i_read && $stable(i_address))
		else begin
			fail_cnt++;
			$error("master request changed while waitrequest was high");
		end

endmodule

bind det_engine det_asserts u_engine_chk (
	.clk(clk), .reset(reset), .i_idle(state == det_pkg::IDLE), .i_wr_we(o_wr_we),
	.i_done(o_done), .i_hold(1'b0), .i_read(1'b0), .i_address(32'd0)
);

bind det_dma det_asserts u_dma_chk (
	.clk(clk), .reset(reset), .i_idle(1'b0), .i_wr_we(1'b0), .i_done(1'b0),
	.i_hold(i_waitrequest), .i_read(o_read), .i_address(o_address)
);

// ==== verification/det_tb.sv ====
// self-checking testbench for the determinant accelerator; run as top, holds the bus memory model
`timescale 1ns/1ns

module det_tb;
	import det_pkg::*;

	localparam int        CLK_PERIOD = 20;
	localparam int        NUM_TESTS  = 21;           // reset check plus 20 runs
	localparam int        MEM_WORDS  = 1024;
	localparam bus_addr_t MEM_BASE   = 32'h0001_0000;
	localparam integer    SEED       = 32'h1e86_0b29;

	logic      clk               = 1'b0;
	logic      reset             = 1'b1;
	logic      i_slave_address   = 1'b0;
	logic      i_slave_write     = 1'b0;
	logic      i_slave_read      = 1'b0;
	det_word_t i_slave_writedata = '0;
	logic      i_waitrequest     = 1'b0;
	det_word_t i_readdata        = '0;
	logic      i_readdatavalid   = 1'b0;
	det_word_t o_slave_readdata;
	logic      o_irq;
	bus_addr_t o_address;
	logic      o_read;

	integer      seed = SEED;
	int          err_cnt;
	int          chk_cnt;
	int          run_cnt;
	int          checked_cnt;
	int          accept_cnt;         // accepted master reads over all runs
	int          acc_base;           // accept_cnt when the current run started
	int          cycle_cnt;
	logic [31:0] last_due = '0;
	bus_addr_t   run_ptr;
	int          mat [4][4];         // row-major matrix under test
	det_word_t   bus_mem [MEM_WORDS];
	logic [63:0] rsp_q [$];          // due cycle in the upper half and data below
	string       exp_name [$];
	det_word_t   exp_result [$];
	det_word_t   exp_status [$];
	int          exp_reads [$];

	det_top UUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// reference model

	// cofactor expansion unrolled into a signed sum over column permutations
	function automatic longint ref_value(input int n);
		longint det;
		longint term;
		int     p [4];
		int     code;
		int     inv;
		det = 0;
		for (int idx = 0; idx < n ** n; idx++) begin
			code = idx;
			for (int r = 0; r < n; r++) begin
				p[r] = code % n;
				code = code / n;
			end
			inv  = 0;
			term = 1;
			for (int r = 0; r < n; r++) begin
				term *= mat[r][p[r]];
				for (int s = r + 1; s < n; s++) begin
					if (p[s] == p[r])
						term = 0; // repeated column
					else if (p[s] < p[r])
						inv++;
				end
			end
			det += (inv % 2) ? -term : term;
		end
		return det;
	endfunction

	function automatic det_word_t ref_det(input int n);
		longint d;
		d = ref_value(n);
		if (d == 0)
			return SINGULAR_RESULT;
		return det_word_t'(d);
	endfunction

	task automatic check_value(input string name, input det_word_t expected,
			input det_word_t actual);
		chk_cnt++;
		if (expected !== actual) begin
			err_cnt++;
			$display("error %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus memory model

	// acceptance taken at the rising edge like the DUT
	always @(posedge clk) begin : mem_accept
		logic [31:0] due;
		int          idx;
		cycle_cnt = cycle_cnt + 1;
		if (o_read && !i_waitrequest) begin
			check_value("read address", run_ptr + 32'd4 * (accept_cnt - acc_base),
				o_address);
			idx = (o_address - MEM_BASE) >> 2;
			if (idx >= MEM_WORDS) begin
				err_cnt++;
				$display("master read outside the bus memory model at %h", o_address);
				idx = 0;
			end
			due = cycle_cnt + 1 + ($unsigned($random(seed)) % 4); // 0..3 extra cycles
			if (due <= last_due)
				due = last_due + 1; // in order with one beat per cycle
			last_due = due;
			rsp_q.push_back({due, bus_mem[idx]});
			accept_cnt = accept_cnt + 1;
		end
	end

	always @(negedge clk) begin : mem_respond
		logic [63:0] rsp;
		if (rsp_q.size() > 0 && rsp_q[0][63:32] == cycle_cnt + 1) begin
			rsp             = rsp_q.pop_front();
			i_readdata      = rsp[31:0];
			i_readdatavalid = 1'b1;
		end else begin
			i_readdatavalid = 1'b0;
		end
		i_waitrequest = ($unsigned($random(seed)) % 4) == 0; // stall about one in four
	end

	////////////////////////////////////////////////////////////////////////////
	// slave access and run control

	task automatic slave_write(input logic addr, input det_word_t data);
		@(negedge clk);
		i_slave_address   = addr;
		i_slave_writedata = data;
		i_slave_write     = 1'b1;
		@(negedge clk);
		i_slave_write = 1'b0;
	endtask

	task automatic slave_read(input logic addr, output det_word_t data);
		@(negedge clk);
		i_slave_address = addr;
		i_slave_read    = 1'b1;
		@(posedge clk);
		data = o_slave_readdata; // zero wait data held up to the edge
		@(negedge clk);
		i_slave_read = 1'b0;
	endtask

	task automatic random_fill();
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				mat[r][c] = $random(seed) % 10; // -9..9
	endtask

	// copies mat to a random spot in memory, queues expectations, kicks the DUT
	task automatic start_run(input string name, input int n);
		bus_addr_t ptr;
		ptr = MEM_BASE + 32'd4 * ($unsigned($random(seed)) % (MEM_WORDS - 16));
		for (int r = 0; r < n; r++)
			for (int c = 0; c < n; c++)
				bus_mem[(ptr - MEM_BASE) / 4 + r * n + c] = mat[r][c];
		exp_name.push_back(name);
		exp_result.push_back(ref_det(n));
		exp_status.push_back((ref_value(n) == 0) ? (32'd1 << STAT_SINGULAR_BIT) : 32'd0);
		exp_reads.push_back(n * n);
		run_ptr  = ptr;
		acc_base = accept_cnt;
		run_cnt++;
		slave_write(REG_PTR, ptr);
		slave_write(REG_LEN, n);
	endtask

	// one signed byte per entry, four entries per row
	task automatic run_packed(input string name, input int n, input logic [127:0] vals);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				mat[r][c] = $signed(vals[127 - 8 * (4 * r + c) -: 8]);
		start_run(name, n);
		wait (checked_cnt == run_cnt);
	endtask

	// result and status after every interrupt
	always begin : compare
		det_word_t rd;
		string     name;
		@(posedge o_irq);
		if (exp_name.size() == 0) begin
			err_cnt++;
			$display("interrupt raised with no run in flight");
		end else begin
			name = exp_name.pop_front();
			slave_read(REG_RESULT, rd);
			check_value({name, " result"}, exp_result.pop_front(), rd);
			check_value({name, " irq after read"}, 32'd0, o_irq);
			slave_read(REG_STATUS, rd);
			check_value({name, " status"}, exp_status.pop_front(), rd);
			check_value({name, " reads"}, exp_reads.pop_front(), accept_cnt - acc_base);
			checked_cnt++;
		end
	end

	initial begin : stimulus
		det_word_t rd;
		int        n;
		int        asrt_cnt;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		slave_read(REG_STATUS, rd);
		check_value("reset status", 32'd0, rd);
		check_value("reset irq", 32'd0, o_irq);

		for (int t = 0; t < 12; t++) begin
			n = 1 + $unsigned($random(seed)) % 4;
			random_fill();
			start_run($sformatf("random_%0d", t), n);
			wait (checked_cnt == run_cnt);
		end

		// zero leading pivots with odd and even remaining counts
		run_packed("rotate_odd", 3, 128'h00010200_03040500_06070900_00000000);
		run_packed("rotate_even", 4, 128'h00020103_01000201_02010001_01030102);
		run_packed("rotate_mid", 3, 128'h01020300_02040500_03070100_00000000);
		run_packed("equal_rows", 3, 128'h01020300_04050600_01020300_00000000);
		run_packed("zero_column", 4, 128'h01000203_04000506_07000809_01000101);
		run_packed("zero_1x1", 1, 128'h0);
		run_packed("det_minus_one", 2, 128'h01020000_01010000_00000000_00000000);

		// size write in the middle of a run
		random_fill();
		start_run("busy_len", 4);
		repeat (30) @(negedge clk);
		slave_read(REG_STATUS, rd);
		check_value("busy_len busy bit", 32'd1, rd[STAT_BUSY_BIT]);
		slave_write(REG_LEN, 32'd2);
		wait (checked_cnt == run_cnt);

		asrt_cnt = UUT.u_engine.u_engine_chk.fail_cnt + UUT.u_dma.u_dma_chk.fail_cnt;
		err_cnt += asrt_cnt;
		$display("checks %0d errors %0d assertion failures %0d", chk_cnt, err_cnt, asrt_cnt);
		if (err_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		repeat (NUM_TESTS * 4000) @(posedge clk);
		$display("timeout, the run did not finish within %0d cycles", NUM_TESTS * 4000);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
